//--- logic/rs_mul_consts.svh
`ifndef RS_MUL_CONSTS_SVH
`define RS_MUL_CONSTS_SVH

// Station geometry
`define RS_ENTRIES 8
`define RS_IDX_W   3

// Operand widths
`define RS_TAG_W   8
`define RS_DATA_W  32

// Result broadcasts, lowest index has priority
`define RS_NUM_CDB 4
`define CDB_ALU    0
`define CDB_MUL    1
`define CDB_DIV    2
`define CDB_LOAD   3

`endif

//--- logic/rs_mul_pkg.sv
`include "rs_mul_consts.svh"

package rs_mul_pkg;

    typedef struct packed {
        logic                  valid;
        logic [`RS_TAG_W-1:0]  tag;
        logic [`RS_DATA_W-1:0] data;
    } cdb_t;

    typedef cdb_t [`RS_NUM_CDB-1:0] cdb_bus_t;

    typedef struct packed {
        logic [`RS_TAG_W-1:0]  tag;
        logic [`RS_DATA_W-1:0] data;
        logic                  ready;
    } rs_src_t;

    typedef struct packed {
        logic                  occupied;
        logic [`RS_DATA_W-1:0] pc;
        logic [`RS_TAG_W-1:0]  rd;
        rs_src_t               src1;
        rs_src_t               src2;
    } rs_entry_t;

    typedef struct packed {
        logic                  valid;
        logic [`RS_DATA_W-1:0] pc;
        logic [`RS_TAG_W-1:0]  rd;
        rs_src_t               src1;
        rs_src_t               src2;
    } rs_dispatch_t;

    // Fill a waiting source from the broadcasts, lowest index wins
    function automatic rs_src_t src_wakeup(rs_src_t src, cdb_bus_t cdb);
        rs_src_t res;
        res = src;
        if (!src.ready) begin
            for (int i = `RS_NUM_CDB - 1; i >= 0; i--) begin
                if (cdb[i].valid && cdb[i].tag == src.tag) begin
                    res.data  = cdb[i].data;
                    res.ready = 1'b1;
                end
            end
        end
        return res;
    endfunction

endpackage

//--- logic/rs_select_if.sv
`timescale 1ns/1ps
`include "rs_mul_consts.svh"

interface rs_select_if import rs_mul_pkg::*; ();

    rs_entry_t [`RS_ENTRIES-1:0] entries;
    logic [`RS_ENTRIES-1:0]      ready;    // Occupied and both sources ready
    logic [`RS_IDX_W-1:0]        head;     // Oldest slot
    logic                        clear_valid;
    logic [`RS_IDX_W-1:0]        clear_idx;

    modport storage (
        output entries,
        output ready,
        output head,
        input  clear_valid,
        input  clear_idx
    );

    modport select (
        input  entries,
        input  ready,
        input  head,
        output clear_valid,
        output clear_idx
    );

endinterface

//--- logic/rs_dispatch_capture.sv
`timescale 1ns/1ps
`include "rs_mul_consts.svh"

module rs_dispatch_capture import rs_mul_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  rs_dispatch_t dispatch_in,
    input  cdb_bus_t     cdb,
    output rs_dispatch_t alloc
);

    rs_dispatch_t bypassed;

    // Each source looks at the same-cycle broadcasts on its own
    always_comb begin
        bypassed      = dispatch_in;
        bypassed.src1 = src_wakeup(dispatch_in.src1, cdb);
        bypassed.src2 = src_wakeup(dispatch_in.src2, cdb);
    end

    always_ff @(posedge clk) begin
        alloc <= bypassed;
        if (reset) begin
            alloc.valid <= 1'b0;
        end
    end

endmodule

//--- logic/rs_entry_array.sv
`timescale 1ns/1ps
`include "rs_mul_consts.svh"

module rs_entry_array import rs_mul_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  rs_dispatch_t alloc,
    input  cdb_bus_t     cdb,
    rs_select_if.storage sel
);

    rs_entry_t [`RS_ENTRIES-1:0] slots;
    logic [`RS_IDX_W-1:0]        tail;
    logic [`RS_IDX_W-1:0]        head;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RS_ENTRIES; i++) begin
                slots[i].occupied <= 1'b0;
            end
            tail <= '0;
            head <= '0;
        end else begin
            // Wakeup of waiting sources
            for (int i = 0; i < `RS_ENTRIES; i++) begin
                if (slots[i].occupied) begin
                    slots[i].src1 <= src_wakeup(slots[i].src1, cdb);
                    slots[i].src2 <= src_wakeup(slots[i].src2, cdb);
                end
            end

            if (sel.clear_valid) begin
                slots[sel.clear_idx].occupied <= 1'b0;  // Issued this edge
            end

            if (alloc.valid) begin
                slots[tail] <= '{  // Entry also sees this cycle's broadcasts
                    occupied: 1'b1,
                    pc:       alloc.pc,
                    rd:       alloc.rd,
                    src1:     src_wakeup(alloc.src1, cdb),
                    src2:     src_wakeup(alloc.src2, cdb)
                };
                tail <= tail + 1'b1;
            end

            // Skip holes left by out-of-order issue
            if (!slots[head].occupied && head != tail) begin
                head <= head + 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            sel.ready[i] = slots[i].occupied & slots[i].src1.ready & slots[i].src2.ready;
        end
    end

    assign sel.entries = slots;
    assign sel.head    = head;

endmodule

//--- logic/rs_oldest_select.sv
`timescale 1ns/1ps
`include "rs_mul_consts.svh"

module rs_oldest_select import rs_mul_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    rs_select_if.select           sel,
    output logic                  issue_valid,
    output logic [`RS_DATA_W-1:0] issue_pc,
    output logic [`RS_TAG_W-1:0]  issue_rd,
    output logic [`RS_DATA_W-1:0] issue_src1,
    output logic [`RS_DATA_W-1:0] issue_src2
);

    logic [2*`RS_ENTRIES-1:0] ready_dbl;
    logic [`RS_ENTRIES-1:0]   ready_rot;
    logic [`RS_IDX_W-1:0]     pick_off;
    logic [`RS_IDX_W-1:0]     pick_idx;
    logic                     found;
    rs_entry_t                pick;

    // Rotate so bit 0 is the head slot
    assign ready_dbl = {sel.ready, sel.ready} >> sel.head;
    assign ready_rot = ready_dbl[`RS_ENTRIES-1:0];

    always_comb begin
        found    = 1'b0;
        pick_off = '0;
        for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
            if (ready_rot[i]) begin
                found    = 1'b1;
                pick_off = `RS_IDX_W'(i);
            end
        end
    end

    assign pick_idx = sel.head + pick_off;  // Wraps with the index width
    assign pick     = sel.entries[pick_idx];

    assign sel.clear_valid = found;
    assign sel.clear_idx   = pick_idx;

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= found;
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            issue_pc   <= pick.pc;
            issue_rd   <= pick.rd;
            issue_src1 <= pick.src1.data;
            issue_src2 <= pick.src2.data;
        end
    end

endmodule

//--- logic/rs_mul.sv
`timescale 1ns/1ps
`include "rs_mul_consts.svh"

module rs_mul import rs_mul_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  dispatch_valid,
    input  logic [`RS_DATA_W-1:0] dispatch_pc,
    input  logic [`RS_TAG_W-1:0]  dispatch_rd,
    input  logic [`RS_TAG_W-1:0]  src1_tag,
    input  logic [`RS_DATA_W-1:0] src1_data,
    input  logic                  src1_ready,
    input  logic [`RS_TAG_W-1:0]  src2_tag,
    input  logic [`RS_DATA_W-1:0] src2_data,
    input  logic                  src2_ready,

    input  logic                  alu_valid,
    input  logic [`RS_TAG_W-1:0]  alu_tag,
    input  logic [`RS_DATA_W-1:0] alu_data,
    input  logic                  mul_valid,
    input  logic [`RS_TAG_W-1:0]  mul_tag,
    input  logic [`RS_DATA_W-1:0] mul_data,
    input  logic                  div_valid,
    input  logic [`RS_TAG_W-1:0]  div_tag,
    input  logic [`RS_DATA_W-1:0] div_data,
    input  logic                  load_valid,
    input  logic [`RS_TAG_W-1:0]  load_tag,
    input  logic [`RS_DATA_W-1:0] load_data,

    output logic                  issue_valid,
    output logic [`RS_DATA_W-1:0] issue_pc,
    output logic [`RS_TAG_W-1:0]  issue_rd,
    output logic [`RS_DATA_W-1:0] issue_src1,
    output logic [`RS_DATA_W-1:0] issue_src2
);

    cdb_bus_t     cdb;
    rs_dispatch_t dispatch_in;
    rs_dispatch_t alloc;

    assign cdb[`CDB_ALU]  = '{valid: alu_valid,  tag: alu_tag,  data: alu_data};
    assign cdb[`CDB_MUL]  = '{valid: mul_valid,  tag: mul_tag,  data: mul_data};
    assign cdb[`CDB_DIV]  = '{valid: div_valid,  tag: div_tag,  data: div_data};
    assign cdb[`CDB_LOAD] = '{valid: load_valid, tag: load_tag, data: load_data};

    assign dispatch_in = '{
        valid: dispatch_valid,
        pc:    dispatch_pc,
        rd:    dispatch_rd,
        src1:  '{tag: src1_tag, data: src1_data, ready: src1_ready},
        src2:  '{tag: src2_tag, data: src2_data, ready: src2_ready}
    };

    rs_select_if sel_if ();

    rs_dispatch_capture u_capture (
        .clk         (clk),
        .reset       (reset),
        .dispatch_in (dispatch_in),
        .cdb         (cdb),
        .alloc       (alloc)
    );

    rs_entry_array u_entries (
        .clk   (clk),
        .reset (reset),
        .alloc (alloc),
        .cdb   (cdb),
        .sel   (sel_if.storage)
    );

    rs_oldest_select u_select (
        .clk         (clk),
        .reset       (reset),
        .sel         (sel_if.select),
        .issue_valid (issue_valid),
        .issue_pc    (issue_pc),
        .issue_rd    (issue_rd),
        .issue_src1  (issue_src1),
        .issue_src2  (issue_src2)
    );

endmodule

//--- dv/rs_mul_checker.sv
`timescale 1ns/1ps
`include "rs_mul_consts.svh"

module rs_mul_checker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  logic [`RS_DATA_W-1:0] issue_pc,
    input  logic [`RS_TAG_W-1:0]  issue_rd,
    input  logic [`RS_DATA_W-1:0] issue_src1,
    input  logic [`RS_DATA_W-1:0] issue_src2,
    output int                    error_count,
    output int                    issue_count
);

    logic [`RS_DATA_W-1:0] exp_pc [$];
    logic [`RS_TAG_W-1:0]  exp_rd [$];
    logic [`RS_DATA_W-1:0] exp_src1 [$];
    logic [`RS_DATA_W-1:0] exp_src2 [$];
    int                    exp_test [$];
    string                 test_name [0:7];
    int                    test_issues [0:7];
    int                    test_errors [0:7];
    int                    cur_test;

    initial begin
        error_count = 0;
        issue_count = 0;
        for (int i = 0; i < 8; i++) begin
            test_issues[i] = 0;
            test_errors[i] = 0;
        end
    end

    task automatic add_expected(input int test, input logic [`RS_DATA_W-1:0] pc,
                                input logic [`RS_TAG_W-1:0] rd,
                                input logic [`RS_DATA_W-1:0] src1,
                                input logic [`RS_DATA_W-1:0] src2);
        exp_test.push_back(test);
        exp_pc.push_back(pc);
        exp_rd.push_back(rd);
        exp_src1.push_back(src1);
        exp_src2.push_back(src2);
    endtask

    task automatic name_test(input int test, input string name);
        test_name[test] = name;
    endtask

    function automatic int remaining();
        return exp_pc.size();
    endfunction

    task automatic compare(input string signal, input logic [31:0] got,
                           input logic [31:0] want, input int test);
        if (got !== want) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h (test %0d)",
                     signal, got, want, test);
            error_count++;
            test_errors[test]++;
        end
    endtask

    task automatic report_test(input int test);
        if (test_errors[test] == 0) begin
            $display("test %0d %s: %0d issues ok", test, test_name[test], test_issues[test]);
        end else begin
            $display("test %0d %s: %0d issues, %0d errors",
                     test, test_name[test], test_issues[test], test_errors[test]);
        end
    endtask

    // Issue register is stable at the falling edge
    always @(negedge clk) begin
        if (!reset && issue_valid === 1'b1) begin
            if (exp_pc.size() == 0) begin
                $display("Unexpected issue of pc 0x%08h with no expected issue left", issue_pc);
                error_count++;
            end else begin
                cur_test = exp_test.pop_front();
                compare("issue_pc", issue_pc, exp_pc.pop_front(), cur_test);
                compare("issue_rd", 32'(issue_rd), 32'(exp_rd.pop_front()), cur_test);
                compare("issue_src1", issue_src1, exp_src1.pop_front(), cur_test);
                compare("issue_src2", issue_src2, exp_src2.pop_front(), cur_test);
                issue_count++;
                test_issues[cur_test]++;
                if (exp_test.size() == 0 || exp_test[0] != cur_test) begin
                    report_test(cur_test);  // Last issue of this test
                end
            end
        end
    end

endmodule

//--- dv/rs_mul_tb.sv
`timescale 1ns/1ps
`include "rs_mul_consts.svh"

module rs_mul_tb import rs_mul_pkg::*; ();

    typedef struct packed {
        rs_dispatch_t disp;
        cdb_bus_t     cdb;
    } stim_row_t;

    logic                  clk;
    logic                  reset;
    logic                  dispatch_valid;
    logic [`RS_DATA_W-1:0] dispatch_pc;
    logic [`RS_TAG_W-1:0]  dispatch_rd;
    logic [`RS_TAG_W-1:0]  src1_tag;
    logic [`RS_DATA_W-1:0] src1_data;
    logic                  src1_ready;
    logic [`RS_TAG_W-1:0]  src2_tag;
    logic [`RS_DATA_W-1:0] src2_data;
    logic                  src2_ready;
    logic                  alu_valid;
    logic [`RS_TAG_W-1:0]  alu_tag;
    logic [`RS_DATA_W-1:0] alu_data;
    logic                  mul_valid;
    logic [`RS_TAG_W-1:0]  mul_tag;
    logic [`RS_DATA_W-1:0] mul_data;
    logic                  div_valid;
    logic [`RS_TAG_W-1:0]  div_tag;
    logic [`RS_DATA_W-1:0] div_data;
    logic                  load_valid;
    logic [`RS_TAG_W-1:0]  load_tag;
    logic [`RS_DATA_W-1:0] load_data;
    logic                  issue_valid;
    logic [`RS_DATA_W-1:0] issue_pc;
    logic [`RS_TAG_W-1:0]  issue_rd;
    logic [`RS_DATA_W-1:0] issue_src1;
    logic [`RS_DATA_W-1:0] issue_src2;
    int                    error_count;
    int                    issue_count;

    stim_row_t   stim [$];
    stim_row_t   cur;
    int          cycle = 0;
    int          cycle_limit = 0;
    int unsigned seed;

    rs_mul u_rs_mul (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_pc    (dispatch_pc),
        .dispatch_rd    (dispatch_rd),
        .src1_tag       (src1_tag),
        .src1_data      (src1_data),
        .src1_ready     (src1_ready),
        .src2_tag       (src2_tag),
        .src2_data      (src2_data),
        .src2_ready     (src2_ready),
        .alu_valid      (alu_valid),
        .alu_tag        (alu_tag),
        .alu_data       (alu_data),
        .mul_valid      (mul_valid),
        .mul_tag        (mul_tag),
        .mul_data       (mul_data),
        .div_valid      (div_valid),
        .div_tag        (div_tag),
        .div_data       (div_data),
        .load_valid     (load_valid),
        .load_tag       (load_tag),
        .load_data      (load_data),
        .issue_valid    (issue_valid),
        .issue_pc       (issue_pc),
        .issue_rd       (issue_rd),
        .issue_src1     (issue_src1),
        .issue_src2     (issue_src2)
    );

    rs_mul_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_pc    (issue_pc),
        .issue_rd    (issue_rd),
        .issue_src1  (issue_src1),
        .issue_src2  (issue_src2),
        .error_count (error_count),
        .issue_count (issue_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic rs_src_t src_op(input logic [`RS_TAG_W-1:0] tag,
                                       input logic [`RS_DATA_W-1:0] data,
                                       input logic ready);
        rs_src_t s;
        s.tag   = tag;
        s.data  = data;
        s.ready = ready;
        return s;
    endfunction

    task automatic dispatch_op(input logic [`RS_DATA_W-1:0] pc, input logic [`RS_TAG_W-1:0] rd,
                               input rs_src_t s1, input rs_src_t s2);
        cur.disp.valid = 1'b1;
        cur.disp.pc    = pc;
        cur.disp.rd    = rd;
        cur.disp.src1  = s1;
        cur.disp.src2  = s2;
    endtask

    task automatic broadcast(input int idx, input logic [`RS_TAG_W-1:0] tag,
                             input logic [`RS_DATA_W-1:0] data, input logic valid);
        cur.cdb[idx].valid = valid;
        cur.cdb[idx].tag   = tag;
        cur.cdb[idx].data  = data;
    endtask

    task automatic end_row();
        stim.push_back(cur);
        cur = '0;
    endtask

    task automatic idle_rows(input int n);
        repeat (n) end_row();
    endtask

    task automatic expect_issue(input int test, input logic [`RS_DATA_W-1:0] pc,
                                input logic [`RS_TAG_W-1:0] rd,
                                input logic [`RS_DATA_W-1:0] s1,
                                input logic [`RS_DATA_W-1:0] s2);
        u_checker.add_expected(test, pc, rd, s1, s2);
    endtask

    task automatic build_tables();
        logic [`RS_DATA_W-1:0] wake [0:7];
        logic [`RS_DATA_W-1:0] other [0:7];
        logic [`RS_DATA_W-1:0] a;
        logic [`RS_DATA_W-1:0] b;
        cur = '0;
        u_checker.name_test(1, "ready at dispatch");
        u_checker.name_test(2, "dispatch bypass");
        u_checker.name_test(3, "broadcast wakeup");
        u_checker.name_test(4, "broadcast priority");
        u_checker.name_test(5, "younger first");
        u_checker.name_test(6, "full station and reuse");

        for (int i = 0; i < 3; i++) begin
            a = 32'h1111_0001 + 32'(i);
            b = 32'h2222_0001 + 32'(i);
            dispatch_op(32'h1000 + 32'(4 * i), 8'(8'h01 + i), src_op(8'h10, a, 1'b1),
                        src_op(8'h11, b, 1'b1));
            end_row();
            expect_issue(1, 32'h1000 + 32'(4 * i), 8'(8'h01 + i), a, b);
        end
        idle_rows(4);

        dispatch_op(32'h1100, 8'h04, src_op(8'h21, 32'hdead_0021, 1'b0),
                    src_op(8'h00, 32'h2222_0010, 1'b1));
        broadcast(`CDB_MUL, 8'h21, 32'hbeef_0021, 1'b1);
        end_row();
        dispatch_op(32'h1104, 8'h05, src_op(8'h00, 32'h1111_0011, 1'b1),
                    src_op(8'h22, 32'hdead_0022, 1'b0));
        broadcast(`CDB_ALU, 8'h22, 32'hbad0_0022, 1'b0);  // Invalid, so load wins
        broadcast(`CDB_LOAD, 8'h22, 32'hbeef_0022, 1'b1);
        end_row();
        dispatch_op(32'h1108, 8'h06, src_op(8'h23, 32'hdead_0023, 1'b0),
                    src_op(8'h00, 32'h2222_0012, 1'b1));
        broadcast(`CDB_DIV, 8'h23, 32'hbad0_0023, 1'b0);
        end_row();
        dispatch_op(32'h110c, 8'h07, src_op(8'h26, 32'hdead_0026, 1'b0),
                    src_op(8'h27, 32'hdead_0027, 1'b0));
        broadcast(`CDB_ALU, 8'h26, 32'hbeef_0026, 1'b1);
        broadcast(`CDB_DIV, 8'h27, 32'hbeef_0027, 1'b1);
        end_row();
        idle_rows(1);
        broadcast(`CDB_ALU, 8'h23, 32'hbeef_0023, 1'b1);
        end_row();
        expect_issue(2, 32'h1100, 8'h04, 32'hbeef_0021, 32'h2222_0010);
        expect_issue(2, 32'h1104, 8'h05, 32'h1111_0011, 32'hbeef_0022);
        expect_issue(2, 32'h110c, 8'h07, 32'hbeef_0026, 32'hbeef_0027);
        expect_issue(2, 32'h1108, 8'h06, 32'hbeef_0023, 32'h2222_0012);
        idle_rows(4);

        dispatch_op(32'h1200, 8'h08, src_op(8'h31, 32'hdead_0031, 1'b0),
                    src_op(8'h32, 32'hdead_0032, 1'b0));
        end_row();
        dispatch_op(32'h1204, 8'h09, src_op(8'h33, 32'hdead_0033, 1'b0),
                    src_op(8'h33, 32'hdead_1033, 1'b0));
        end_row();
        broadcast(`CDB_MUL, 8'h31, 32'hcafe_0031, 1'b1);
        broadcast(`CDB_ALU, 8'h32, 32'hbad0_0032, 1'b0);
        broadcast(`CDB_DIV, 8'h33, 32'hcafe_0033, 1'b1);  // Wakes both sources of one entry
        end_row();
        idle_rows(2);
        broadcast(`CDB_LOAD, 8'h32, 32'hcafe_0032, 1'b1);
        end_row();
        expect_issue(3, 32'h1204, 8'h09, 32'hcafe_0033, 32'hcafe_0033);
        expect_issue(3, 32'h1200, 8'h08, 32'hcafe_0031, 32'hcafe_0032);
        idle_rows(4);

        dispatch_op(32'h1300, 8'h0a, src_op(8'h41, 32'hdead_0041, 1'b0),
                    src_op(8'h00, 32'h2222_0041, 1'b1));
        broadcast(`CDB_MUL, 8'h41, 32'haaaa_0141, 1'b1);
        broadcast(`CDB_LOAD, 8'h41, 32'haaaa_0341, 1'b1);
        end_row();
        dispatch_op(32'h1304, 8'h0b, src_op(8'h00, 32'h1111_0042, 1'b1),
                    src_op(8'h42, 32'hdead_0042, 1'b0));
        end_row();
        idle_rows(1);
        broadcast(`CDB_ALU, 8'h42, 32'hbbbb_0042, 1'b1);
        broadcast(`CDB_DIV, 8'h42, 32'hbbbb_0242, 1'b1);
        broadcast(`CDB_LOAD, 8'h42, 32'hbbbb_0342, 1'b1);
        end_row();
        expect_issue(4, 32'h1300, 8'h0a, 32'haaaa_0141, 32'h2222_0041);
        expect_issue(4, 32'h1304, 8'h0b, 32'h1111_0042, 32'hbbbb_0042);
        idle_rows(4);

        dispatch_op(32'h1400, 8'h0c, src_op(8'h51, 32'hdead_0051, 1'b0),
                    src_op(8'h00, 32'h2222_0051, 1'b1));
        end_row();
        dispatch_op(32'h1404, 8'h0d, src_op(8'h00, 32'h1111_0052, 1'b1),
                    src_op(8'h00, 32'h2222_0052, 1'b1));
        end_row();
        idle_rows(2);
        broadcast(`CDB_MUL, 8'h51, 32'hdddd_0051, 1'b1);
        end_row();
        expect_issue(5, 32'h1404, 8'h0d, 32'h1111_0052, 32'h2222_0052);
        expect_issue(5, 32'h1400, 8'h0c, 32'hdddd_0051, 32'h2222_0051);
        idle_rows(10);  // Head catches up with tail

        for (int i = 0; i < `RS_ENTRIES; i++) begin
            wake[i]  = $urandom;
            other[i] = $urandom;
            dispatch_op(32'h1500 + 32'(4 * i), 8'(8'h70 + i),
                        src_op(8'(8'h61 + i), $urandom, 1'b0), src_op(8'h00, other[i], 1'b1));
            end_row();
            expect_issue(6, 32'h1500 + 32'(4 * i), 8'(8'h70 + i), wake[i], other[i]);
        end
        idle_rows(1);
        for (int i = 0; i < 4; i++) begin
            broadcast(i, 8'(8'h61 + i), wake[i], 1'b1);
        end
        end_row();
        for (int i = 4; i < `RS_ENTRIES; i++) begin
            broadcast(i - 4, 8'(8'h61 + i), wake[i], 1'b1);
        end
        end_row();
        idle_rows(12);
        for (int i = 0; i < 4; i++) begin
            a = $urandom;
            b = $urandom;
            dispatch_op(32'h1600 + 32'(4 * i), 8'(8'h80 + i), src_op(8'h00, a, 1'b1),
                        src_op(8'h00, b, 1'b1));
            end_row();
            expect_issue(6, 32'h1600 + 32'(4 * i), 8'(8'h80 + i), a, b);
        end
        idle_rows(6);
    endtask

    task automatic apply_row(input stim_row_t row);
        dispatch_valid = row.disp.valid;
        dispatch_pc    = row.disp.pc;
        dispatch_rd    = row.disp.rd;
        src1_tag       = row.disp.src1.tag;
        src1_data      = row.disp.src1.data;
        src1_ready     = row.disp.src1.ready;
        src2_tag       = row.disp.src2.tag;
        src2_data      = row.disp.src2.data;
        src2_ready     = row.disp.src2.ready;
        alu_valid      = row.cdb[`CDB_ALU].valid;
        alu_tag        = row.cdb[`CDB_ALU].tag;
        alu_data       = row.cdb[`CDB_ALU].data;
        mul_valid      = row.cdb[`CDB_MUL].valid;
        mul_tag        = row.cdb[`CDB_MUL].tag;
        mul_data       = row.cdb[`CDB_MUL].data;
        div_valid      = row.cdb[`CDB_DIV].valid;
        div_tag        = row.cdb[`CDB_DIV].tag;
        div_data       = row.cdb[`CDB_DIV].data;
        load_valid     = row.cdb[`CDB_LOAD].valid;
        load_tag       = row.cdb[`CDB_LOAD].tag;
        load_data      = row.cdb[`CDB_LOAD].data;
    endtask

    initial begin
        seed = 32'h80e8_7f78;
        seed = $urandom(seed);  // Seed the generator once
        reset = 1'b1;
        build_tables();
        cycle_limit = stim.size() + 4 * `RS_ENTRIES + 20;
        apply_row(cur);
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;

        for (int i = 0; i < stim.size(); i++) begin
            @(posedge clk);
            #1 apply_row(stim[i]);
        end

        while (u_checker.remaining() > 0) @(posedge clk);
        repeat (2 * `RS_ENTRIES) @(posedge clk);  // Catch stray issues

        $display("Checked %0d issues, %0d errors", issue_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle_limit > 0 && cycle >= cycle_limit) begin
            $display("Timeout after %0d cycles, %0d expected issues never arrived",
                     cycle, u_checker.remaining());
            $display("*** FAILED ***");
            $finish;
        end
    end

endmodule

//--- rs_mul.f
+incdir+logic
logic/rs_mul_pkg.sv
logic/rs_select_if.sv
logic/rs_dispatch_capture.sv
logic/rs_entry_array.sv
logic/rs_oldest_select.sv
logic/rs_mul.sv
dv/rs_mul_checker.sv
dv/rs_mul_tb.sv

//--- Bender.yml
package:
  name: rs_mul

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/rs_mul_pkg.sv
      - logic/rs_select_if.sv
      - logic/rs_dispatch_capture.sv
      - logic/rs_entry_array.sv
      - logic/rs_oldest_select.sv
      - logic/rs_mul.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/rs_mul_checker.sv
      - dv/rs_mul_tb.sv
